// File: src/mont_pkg.sv
package mont_pkg;

    // Controller states, one ADD/WAIT pair per adder step
    typedef enum logic [3:0] {
        IDLE,
        LOAD,
        PRE_B3,
        WAIT_B3,
        PRE_M3,
        WAIT_M3,
        ADD_B,
        WAIT_B,
        ADD_M,
        WAIT_M,
        RED,
        WAIT_RED,
        DONE
    } mont_state_e;

    // What the adder is fed with and where its result goes
    typedef enum logic [2:0] {
        OP_B3,
        OP_M3,
        OP_BQ,
        OP_MQ,
        OP_RED
    } add_op_e;

    // Controller to datapath
    typedef struct packed {
        logic    load;
        logic    add_start;
        add_op_e op;
        logic    commit;
    } mont_ctrl_t;

    // Datapath to controller
    typedef struct packed {
        logic add_done;
    } mont_status_t;

endpackage

// File: src/mont_adder.sv
`timescale 1ns/1ps

module mont_adder #(
    parameter int N       = 1024,
    parameter int CHUNK_W = 64
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic         start,
    input  logic         subtract,
    input  logic [N+2:0] in_a,
    input  logic [N+2:0] in_b,
    output logic [N+3:0] sum,
    output logic         done
);

    localparam int W      = N + 3;
    localparam int NCHUNK = (W + CHUNK_W - 1) / CHUNK_W;
    localparam int PW     = NCHUNK * CHUNK_W;
    localparam int CNT_W  = $clog2(NCHUNK + 1);

    logic [PW-1:0]    a_pad;
    logic [PW-1:0]    b_pad;
    logic [PW-1:0]    a_cur;
    logic [PW-1:0]    b_cur;
    logic [PW-1:0]    a_sh;
    logic [PW-1:0]    b_sh;
    logic [PW-1:0]    acc;
    logic [PW:0]      acc_ext;
    logic [CHUNK_W:0] chunk_sum;
    logic             carry;
    logic             sub_q;
    logic             busy;
    logic             last;
    logic [CNT_W-1:0] cnt;

    // Subtraction as a + ~b + 1, the padding is inverted too
    assign a_pad = PW'(in_a);
    assign b_pad = subtract ? ~PW'(in_b) : PW'(in_b);

    // Chunk 0 is taken straight from the inputs in the start cycle
    assign a_cur = start ? a_pad : a_sh;
    assign b_cur = start ? b_pad : b_sh;

    assign chunk_sum = {1'b0, a_cur[CHUNK_W-1:0]}
                     + {1'b0, b_cur[CHUNK_W-1:0]}
                     + (CHUNK_W + 1)'(start ? subtract : carry);

    always_ff @(posedge clk) begin
        if (start || busy) begin
            a_sh  <= a_cur >> CHUNK_W;
            b_sh  <= b_cur >> CHUNK_W;
            // Result chunks enter at the top and end up aligned
            acc   <= PW'({chunk_sum[CHUNK_W-1:0], acc} >> CHUNK_W);
            carry <= chunk_sum[CHUNK_W];
        end
        if (start) begin
            sub_q <= subtract;
        end
    end

    assign last = (cnt == CNT_W'(NCHUNK - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt  <= CNT_W'(1);
                busy <= (NCHUNK > 1);
                done <= (NCHUNK == 1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Top bit is carry out, or the sign when subtracting
    assign acc_ext = {carry ^ sub_q, acc};
    assign sum     = {acc_ext[W], acc[W-1:0]};

    // Operands come from live registers, so a restart mid-run would corrupt them
    a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy);

endmodule

// File: src/mont_digit_select.sv
`timescale 1ns/1ps

module mont_digit_select #(
    parameter int N = 1024
) (
    input  logic [1:0]   a_low,
    input  logic [1:0]   c_low,
    input  logic         m_bit1,
    input  logic [N-1:0] b,
    input  logic [N-1:0] m,
    input  logic [N+1:0] b3,
    input  logic [N+1:0] m3,
    output logic [N+2:0] b_mult,
    output logic [N+2:0] m_mult
);

    logic [1:0] m_inv;
    logic [1:0] cm_prod;
    logic [1:0] q;

    // Multiple 0..3 of x, with 3x precomputed
    function automatic logic [N+2:0] mult_sel(
        input logic [1:0]   digit,
        input logic [N-1:0] x,
        input logic [N+1:0] x3
    );
        logic [N+2:0] r;
        case (digit)
            2'd1:    r = {3'b000, x};
            2'd2:    r = {2'b00, x, 1'b0};
            2'd3:    r = {1'b0, x3};
            default: r = '0;
        endcase
        return r;
    endfunction

    assign b_mult = mult_sel(a_low, b, b3);

    // m is odd, so m^-1 mod 4 is just m mod 4
    assign m_inv = {m_bit1, 1'b1};

    // q = -c * m^-1 mod 4 makes c + q*m divisible by 4
    assign cm_prod = c_low * m_inv;
    assign q       = 2'b00 - cm_prod;

    assign m_mult = mult_sel(q, m, m3);

endmodule

// File: src/mont_datapath.sv
`timescale 1ns/1ps

module mont_datapath #(
    parameter int N       = 1024,
    parameter int CHUNK_W = 64
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [N-1:0]         in_a,
    input  logic [N-1:0]         in_b,
    input  logic [N-1:0]         in_m,
    input  mont_pkg::mont_ctrl_t ctrl,
    output mont_pkg::mont_status_t status,
    output logic [N-1:0]         result
);

    localparam int W = N + 3;

    logic [N-1:0] a;
    logic [N-1:0] b;
    logic [N-1:0] m;
    logic [N+1:0] b3;
    logic [N+1:0] m3;
    logic [W-1:0] c;

    logic [W-1:0] b_mult;
    logic [W-1:0] m_mult;
    logic [W-1:0] add_a;
    logic [W-1:0] add_b;
    logic [W:0]   add_sum;
    logic         add_sub;

    mont_digit_select #(
        .N (N)
    ) i_digit_select (
        .a_low  (a[1:0]),
        .c_low  (c[1:0]),
        .m_bit1 (m[1]),
        .b      (b),
        .m      (m),
        .b3     (b3),
        .m3     (m3),
        .b_mult (b_mult),
        .m_mult (m_mult)
    );

    // Adder operands per step
    always_comb begin
        add_a   = '0;
        add_b   = '0;
        add_sub = 1'b0;
        case (ctrl.op)
            mont_pkg::OP_B3: begin
                add_a = {3'b000, b};
                add_b = {2'b00, b, 1'b0};
            end
            mont_pkg::OP_M3: begin
                add_a = {3'b000, m};
                add_b = {2'b00, m, 1'b0};
            end
            mont_pkg::OP_BQ: begin
                add_a = c;
                add_b = b_mult;
            end
            mont_pkg::OP_MQ: begin
                add_a = c;
                add_b = m_mult;
            end
            mont_pkg::OP_RED: begin
                add_a   = c;
                add_b   = {3'b000, m};
                add_sub = 1'b1;
            end
            default: begin
                add_a = '0;
            end
        endcase
    end

    mont_adder #(
        .N       (N),
        .CHUNK_W (CHUNK_W)
    ) i_adder (
        .clk      (clk),
        .resetn   (resetn),
        .start    (ctrl.add_start),
        .subtract (add_sub),
        .in_a     (add_a),
        .in_b     (add_b),
        .sum      (add_sum),
        .done     (status.add_done)
    );

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            a <= in_a;
            b <= in_b;
            m <= in_m;
            c <= '0;
        end else if (ctrl.commit) begin
            case (ctrl.op)
                mont_pkg::OP_B3: b3 <= add_sum[N+1:0];
                mont_pkg::OP_M3: m3 <= add_sum[N+1:0];
                mont_pkg::OP_BQ: begin
                    c <= add_sum[W-1:0];
                    // Next digit of a
                    a <= a >> 2;
                end
                // Low two bits are zero by choice of q
                mont_pkg::OP_MQ: c <= {1'b0, add_sum[W:2]};
                mont_pkg::OP_RED: begin
                    // Negative difference means c was already below m
                    if (!add_sum[W]) begin
                        c <= add_sum[W-1:0];
                    end
                end
                default: begin
                    c <= c;
                end
            endcase
        end
    end

    assign result = c[N-1:0];

    // The digit choice for m only works for an odd modulus
    a_m_odd: assert property (@(posedge clk) disable iff (!resetn)
        ctrl.load |=> m[0]);

endmodule

// File: src/mont_ctrl.sv
`timescale 1ns/1ps

module mont_ctrl #(
    parameter int N = 1024
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    output mont_pkg::mont_ctrl_t   ctrl,
    input  mont_pkg::mont_status_t status,
    output logic                   done
);

    localparam int ITERS  = N / 2;
    localparam int ITER_W = $clog2(ITERS) + 1;

    mont_pkg::mont_state_e state;
    mont_pkg::mont_state_e state_next;
    logic [ITER_W-1:0]     iter;
    logic                  last_iter;

    assign last_iter = (iter == ITER_W'(ITERS - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mont_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Iteration count, cleared per run and bumped when a loop pass ends
    always_ff @(posedge clk) begin
        if (!resetn) begin
            iter <= '0;
        end else if (state == mont_pkg::LOAD) begin
            iter <= '0;
        end else if (state == mont_pkg::WAIT_M && status.add_done) begin
            iter <= iter + 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mont_pkg::IDLE:    if (start) state_next = mont_pkg::LOAD;
            mont_pkg::LOAD:    state_next = mont_pkg::PRE_B3;
            mont_pkg::PRE_B3:  state_next = mont_pkg::WAIT_B3;
            mont_pkg::WAIT_B3: if (status.add_done) state_next = mont_pkg::PRE_M3;
            mont_pkg::PRE_M3:  state_next = mont_pkg::WAIT_M3;
            mont_pkg::WAIT_M3: if (status.add_done) state_next = mont_pkg::ADD_B;
            mont_pkg::ADD_B:   state_next = mont_pkg::WAIT_B;
            mont_pkg::WAIT_B:  if (status.add_done) state_next = mont_pkg::ADD_M;
            mont_pkg::ADD_M:   state_next = mont_pkg::WAIT_M;
            mont_pkg::WAIT_M: begin
                if (status.add_done) begin
                    state_next = last_iter ? mont_pkg::RED : mont_pkg::ADD_B;
                end
            end
            mont_pkg::RED:      state_next = mont_pkg::WAIT_RED;
            mont_pkg::WAIT_RED: if (status.add_done) state_next = mont_pkg::DONE;
            mont_pkg::DONE:     state_next = mont_pkg::IDLE;
            default:            state_next = mont_pkg::IDLE;
        endcase
    end

    // Control word decode
    always_comb begin
        ctrl    = '0;
        ctrl.op = mont_pkg::OP_B3;
        // Operands are captured on the edge that sees start
        ctrl.load = (state == mont_pkg::IDLE) && start;
        case (state)
            mont_pkg::PRE_B3, mont_pkg::WAIT_B3: ctrl.op = mont_pkg::OP_B3;
            mont_pkg::PRE_M3, mont_pkg::WAIT_M3: ctrl.op = mont_pkg::OP_M3;
            mont_pkg::ADD_B, mont_pkg::WAIT_B:   ctrl.op = mont_pkg::OP_BQ;
            mont_pkg::ADD_M, mont_pkg::WAIT_M:   ctrl.op = mont_pkg::OP_MQ;
            mont_pkg::RED, mont_pkg::WAIT_RED:   ctrl.op = mont_pkg::OP_RED;
            default:                             ctrl.op = mont_pkg::OP_B3;
        endcase
        ctrl.add_start = (state == mont_pkg::PRE_B3) || (state == mont_pkg::PRE_M3)
                      || (state == mont_pkg::ADD_B) || (state == mont_pkg::ADD_M)
                      || (state == mont_pkg::RED);
        ctrl.commit = status.add_done
                   && ((state == mont_pkg::WAIT_B3) || (state == mont_pkg::WAIT_M3)
                    || (state == mont_pkg::WAIT_B) || (state == mont_pkg::WAIT_M)
                    || (state == mont_pkg::WAIT_RED));
    end

    assign done = (state == mont_pkg::DONE);

    a_iter_bound: assert property (@(posedge clk) disable iff (!resetn)
        iter <= ITER_W'(ITERS));

endmodule

// File: src/montgomery_top.sv
`timescale 1ns/1ps

module montgomery_top #(
    parameter int N       = 1024,
    parameter int CHUNK_W = 64
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic         start,
    input  logic [N-1:0] in_a,
    input  logic [N-1:0] in_b,
    input  logic [N-1:0] in_m,
    output logic [N-1:0] result,
    output logic         done
);

    mont_pkg::mont_ctrl_t   ctrl;
    mont_pkg::mont_status_t status;

    mont_ctrl #(
        .N (N)
    ) i_ctrl (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .ctrl   (ctrl),
        .status (status),
        .done   (done)
    );

    mont_datapath #(
        .N       (N),
        .CHUNK_W (CHUNK_W)
    ) i_datapath (
        .clk    (clk),
        .resetn (resetn),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .ctrl   (ctrl),
        .status (status),
        .result (result)
    );

endmodule

// File: dv/mont_checker.sv
`timescale 1ns/1ps

module mont_checker #(
    parameter int N = 64
) (
    input logic         clk,
    input logic         resetn,
    input logic         start,
    input logic         done,
    input logic [N-1:0] result
);

    string        cur_name = "none";
    logic [N-1:0] cur_exp  = '0;
    logic [N-1:0] held;
    logic         hold_valid;
    logic         running;
    logic         done_q;
    int           n_pass = 0;
    int           n_fail = 0;
    int           n_err  = 0;

    task automatic set_test(input string name, input logic [N-1:0] exp);
        cur_name = name;
        cur_exp  = exp;
    endtask

    task automatic flag_error(input string what);
        n_err++;
        $display("Error: %s", what);
    endtask

    task automatic compare_result();
        if (result === cur_exp) begin
            n_pass++;
            $display("Pass %s: result %h", cur_name, result);
        end else begin
            n_fail++;
            $display("Fail %s: expected %h, actual %h", cur_name, cur_exp, result);
        end
    endtask

    task automatic print_summary();
        $display("Tests: %0d passed, %0d failed, %0d other errors", n_pass, n_fail, n_err);
    endtask

    // Mirrors whether the DUT has accepted a start and not yet finished
    always @(posedge clk) begin
        if (!resetn) begin
            running    <= 1'b0;
            hold_valid <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= (done === 1'b1);
            if (done !== 1'b0 && !running) begin
                flag_error($sformatf("done is not low while no run is in progress (%s)",
                                     cur_name));
            end
            if (done === 1'b1 && done_q) begin
                flag_error($sformatf("done stayed high for more than one cycle (%s)",
                                     cur_name));
            end
            if (hold_valid && !running && result !== held) begin
                flag_error($sformatf("result changed after done before a new start (%s)",
                                     cur_name));
            end
            if (done === 1'b1 && running) begin
                compare_result();
                running    <= 1'b0;
                held       <= result;
                hold_valid <= 1'b1;
            end else if (!running && start) begin
                running    <= 1'b1;
                hold_valid <= 1'b0;
            end
        end
    end

endmodule

// File: dv/tb_montgomery.sv
`timescale 1ns/1ps

module tb_montgomery;

    localparam int N       = 64;
    localparam int CHUNK_W = 16;
    localparam int N_DIR   = 4;
    localparam int N_LCG   = 8;
    localparam int NUM     = N_DIR + N_LCG;
    localparam int NCHUNK  = (N + 3 + CHUNK_W - 1) / CHUNK_W;
    localparam int TIMEOUT_CYCLES = NUM * 2 * ((N + 3) * (NCHUNK + 2));

    logic         clk = 1'b0;
    logic         resetn;
    logic         start;
    logic [N-1:0] in_a;
    logic [N-1:0] in_b;
    logic [N-1:0] in_m;
    logic [N-1:0] result;
    logic         done;
    int           cycles = 0;

    // Stimulus table
    string        names [NUM];
    logic [N-1:0] tab_a [NUM];
    logic [N-1:0] tab_b [NUM];
    logic [N-1:0] tab_m [NUM];
    logic [N-1:0] tab_exp [NUM];
    bit           tab_poke [NUM];
    bit           tab_b2b [NUM];

    montgomery_top #(
        .N       (N),
        .CHUNK_W (CHUNK_W)
    ) i_montgomery_top (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    mont_checker #(
        .N (N)
    ) i_checker (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .done   (done),
        .result (result)
    );

    always #4 clk = ~clk;

    // Ends the run if done stops arriving
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: done never arrived");
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Bit-serial radix-2 Montgomery product, a*b*2^-N mod m
    function automatic logic [N-1:0] ref_mont(
        input logic [N-1:0] a,
        input logic [N-1:0] b,
        input logic [N-1:0] m
    );
        logic [N+1:0] acc;
        acc = '0;
        for (int i = 0; i < N; i++) begin
            if (a[i]) begin
                acc = acc + {2'b00, b};
            end
            if (acc[0]) begin
                acc = acc + {2'b00, m};
            end
            acc = acc >> 1;
        end
        if (acc >= {2'b00, m}) begin
            acc = acc - {2'b00, m};
        end
        return acc[N-1:0];
    endfunction

    task automatic add_entry(input int idx, input string name, input logic [N-1:0] a,
                             input logic [N-1:0] b, input logic [N-1:0] m,
                             input logic [N-1:0] exp);
        names[idx]    = name;
        tab_a[idx]    = a;
        tab_b[idx]    = b;
        tab_m[idx]    = m;
        tab_exp[idx]  = exp;
        tab_poke[idx] = (idx == 5) || (idx == 9);
        tab_b2b[idx]  = (idx == 3) || (idx == 7);
    endtask

    task automatic build_table();
        logic [31:0]  s;
        logic [N-1:0] r;
        logic [N-1:0] m;
        logic [N-1:0] a;
        logic [N-1:0] b;
        s = 32'd67;
        // m = 2^64-3 gives 2^-64 = (2m+1)/3, m = 2^64-1 gives 2^-64 = 1
        add_entry(0, "zero_b", 64'h0123_4567_89AB_CDEF, 64'h0,
                  64'hFFFF_FFFF_FFFF_FFFD, 64'h0);
        add_entry(1, "one_one", 64'h1, 64'h1,
                  64'hFFFF_FFFF_FFFF_FFFD, 64'hAAAA_AAAA_AAAA_AAA9);
        add_entry(2, "one_one_m1", 64'h1, 64'h1,
                  64'hFFFF_FFFF_FFFF_FFFF, 64'h1);
        add_entry(3, "max_sq", 64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFFE,
                  64'hFFFF_FFFF_FFFF_FFFF, 64'h1);
        for (int i = 0; i < N_LCG; i++) begin
            s = lcg_next(s);
            r[63:32] = s;
            s = lcg_next(s);
            r[31:0] = s;
            m = {1'b1, r[62:1], 1'b1};
            s = lcg_next(s);
            r[63:32] = s;
            s = lcg_next(s);
            r[31:0] = s;
            a = r % m;
            s = lcg_next(s);
            r[63:32] = s;
            s = lcg_next(s);
            r[31:0] = s;
            b = r % m;
            add_entry(N_DIR + i, $sformatf("lcg_%0d", i), a, b, m, ref_mont(a, b, m));
        end
    endtask

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        build_table();
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        repeat (3) @(negedge clk);
        for (int i = 0; i < NUM; i++) begin
            i_checker.set_test(names[i], tab_exp[i]);
            in_a  = tab_a[i];
            in_b  = tab_b[i];
            in_m  = tab_m[i];
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            if (tab_poke[i]) begin
                // Second start mid-run with other operands must be ignored
                repeat (40) @(negedge clk);
                in_a  = ~tab_a[i];
                in_b  = ~tab_b[i];
                in_m  = tab_m[i] ^ {N{1'b1}};
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
            while (done !== 1'b1) begin
                @(negedge clk);
            end
            // Back to back means start in the cycle right after done
            if (tab_b2b[i]) begin
                @(negedge clk);
            end else begin
                repeat (4) @(negedge clk);
            end
        end
        repeat (2) @(negedge clk);
        i_checker.print_summary();
        if (i_checker.n_pass + i_checker.n_fail != NUM) begin
            $display("Not every test reported a result");
        end
        if (i_checker.n_pass == NUM && i_checker.n_fail == 0 && i_checker.n_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
src/mont_pkg.sv
src/mont_adder.sv
src/mont_digit_select.sv
src/mont_datapath.sv
src/mont_ctrl.sv
src/montgomery_top.sv
dv/mont_checker.sv
dv/tb_montgomery.sv

// File: Bender.yml
package:
  name: montgomery

sources:
  - files:
      - src/mont_pkg.sv
      - src/mont_adder.sv
      - src/mont_digit_select.sv
      - src/mont_datapath.sv
      - src/mont_ctrl.sv
      - src/montgomery_top.sv
  - target: test
    files:
      - dv/mont_checker.sv
      - dv/tb_montgomery.sv
